// File: build.f
+incdir+common
+incdir+test
common/issue_pkg.sv
verilog/inst_decoder.sv
decode_issue/rename_table.sv
decode_issue/phys_regfile.sv
decode_issue/decode_issue_unit.sv
test/tb_decode_issue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode and issue testbench with Verilator
verilator --binary --timing -f build.f --top-module tb_decode_issue -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: test/issue_model.svh
// ------------------------------------------------
// Reference model for the decode and issue testbench
// Included inside the testbench module body
// ------------------------------------------------

`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// Architectural state, in program order
logic [31:0]            arch_val [32];
logic [`PREG_BITS-1:0]  map_preg [32];
logic                   allocated [`NUM_PREGS];
int                     free_cnt;

// Result of one op from its two operands
function automatic logic [31:0] exec_op(input uop_e op, input logic [31:0] a,
                                        input logic [31:0] b);
  case (op)
    UOP_ADD, UOP_ADDI: return a + b;
    UOP_SUB:           return a - b;
    UOP_AND:           return a & b;
    UOP_OR:            return a | b;
    UOP_MUL:           return a * b;
    default:           return 32'h0;
  endcase
endfunction

// Expected issue_val pattern, mul on pipe 1
function automatic logic [1:0] route_for(input uop_e op);
  return (op == UOP_MUL) ? 2'b10 : 2'b01;
endfunction

task automatic model_reset();
  for (int i = 0; i < 32; i++) begin
    arch_val[i] = 32'h0;
    map_preg[i] = `PREG_BITS'(i);
  end
  // Identity-mapped registers count as live
  for (int p = 0; p < `NUM_PREGS; p++) begin
    allocated[p] = (p < 32);
  end
  free_cnt = `NUM_PREGS - 32;
endtask

// Commit returns the old mapping to the pool
task automatic model_commit(input logic [`PREG_BITS-1:0] ppreg);
  allocated[ppreg] = 1'b0;
  free_cnt++;
endtask

`endif

// File: test/tb_decode_issue.sv
// ------------------------------------------------
// Random testbench for the decode and issue stage
// Stands in for fetch, both pipes, completion, commit
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module tb_decode_issue
  import issue_pkg::*;
;

  localparam int N_INST  = 300;
  localparam int TIMEOUT = N_INST * 40;

  logic       clk;
  logic       rst;
  logic       fetch_val;
  logic       fetch_rdy;
  fetch_pkt_t fetch_pkt;
  logic [1:0] issue_val;
  logic [1:0] issue_rdy;
  issue_pkt_t issue_pkt;
  complete_t  complete_in;
  commit_t    commit_in;

  `include "issue_model.svh"

  decode_issue_unit uut (
    .clk         (clk),
    .rst         (rst),
    .fetch_val   (fetch_val),
    .fetch_rdy   (fetch_rdy),
    .fetch_pkt   (fetch_pkt),
    .issue_val   (issue_val),
    .issue_rdy   (issue_rdy),
    .issue_pkt   (issue_pkt),
    .complete_in (complete_in),
    .commit_in   (commit_in)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------
  // Per-instruction records
  // ------------------------------------------------
  logic [31:0]           inst_word [N_INST];
  uop_e                  inst_uop [N_INST];
  logic [4:0]            inst_rd [N_INST];
  logic [4:0]            inst_rs1 [N_INST];
  logic [4:0]            inst_rs2 [N_INST];
  logic [31:0]           inst_imm [N_INST];
  logic [`PREG_BITS-1:0] inst_preg [N_INST];
  logic [`PREG_BITS-1:0] inst_ppreg [N_INST];
  logic [31:0]           inst_wdata [N_INST];
  int                    comp_due [N_INST];
  int                    comp_cycle [N_INST];
  int                    comp_list[$];
  int                    commit_list[$];
  int                    cyc;

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("** Error: %s got %h expected %h", name, got, exp);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic fail_plain(input string msg);
    $display("Error: %s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else mismatch(name, got, exp);
  endtask

  // Random op over registers 0..7
  task automatic make_inst(input int k);
    int         op;
    logic [11:0] imm12;
    op           = $urandom_range(0, 5);
    inst_rd[k]   = 5'($urandom_range(0, 7));
    inst_rs1[k]  = 5'($urandom_range(0, 7));
    inst_rs2[k]  = 5'($urandom_range(0, 7));
    imm12        = 12'($urandom);
    inst_imm[k]  = {{20{imm12[11]}}, imm12};
    comp_cycle[k] = -1;
    case (op)
      0: inst_uop[k] = UOP_ADD;
      1: inst_uop[k] = UOP_SUB;
      2: inst_uop[k] = UOP_AND;
      3: inst_uop[k] = UOP_OR;
      4: inst_uop[k] = UOP_ADDI;
      default: inst_uop[k] = UOP_MUL;
    endcase
    case (inst_uop[k])
      UOP_ADD: inst_word[k] = {7'h00, inst_rs2[k], inst_rs1[k], 3'b000, inst_rd[k], 7'h33};
      UOP_SUB: inst_word[k] = {7'h20, inst_rs2[k], inst_rs1[k], 3'b000, inst_rd[k], 7'h33};
      UOP_AND: inst_word[k] = {7'h00, inst_rs2[k], inst_rs1[k], 3'b111, inst_rd[k], 7'h33};
      UOP_OR:  inst_word[k] = {7'h00, inst_rs2[k], inst_rs1[k], 3'b110, inst_rd[k], 7'h33};
      UOP_MUL: inst_word[k] = {7'h01, inst_rs2[k], inst_rs1[k], 3'b000, inst_rd[k], 7'h33};
      default: inst_word[k] = {imm12, inst_rs1[k], 3'b000, inst_rd[k], 7'h13};
    endcase
  endtask

  // Checks and model update for an issue at the coming edge
  task automatic take_issue(input int k);
    logic [31:0] a;
    logic [31:0] b;
    a = arch_val[inst_rs1[k]];
    b = (inst_uop[k] == UOP_ADDI) ? inst_imm[k] : arch_val[inst_rs2[k]];
    check_field("issue_val", 32'(issue_val), 32'(route_for(inst_uop[k])));
    check_field("issue_pkt.pc", issue_pkt.pc, 32'h1000 + 32'(k * 4));
    check_field("issue_pkt.seq_num", 32'(issue_pkt.seq_num), 32'(k % 256));
    check_field("issue_pkt.uop", 32'(issue_pkt.uop), 32'(inst_uop[k]));
    check_field("issue_pkt.waddr", 32'(issue_pkt.waddr), 32'(inst_rd[k]));
    check_field("issue_pkt.op1", issue_pkt.op1, a);
    check_field("issue_pkt.op2", issue_pkt.op2, b);
    if (inst_rd[k] != 5'd0) begin
      assert (free_cnt > 0) else fail_plain("instruction issued with an empty free list");
      assert (!allocated[issue_pkt.preg])
        else fail_plain("preg handed out while still allocated");
      check_field("issue_pkt.ppreg", 32'(issue_pkt.ppreg), 32'(map_preg[inst_rd[k]]));
      inst_preg[k]            = issue_pkt.preg;
      inst_ppreg[k]           = issue_pkt.ppreg;
      map_preg[inst_rd[k]]    = issue_pkt.preg;
      allocated[issue_pkt.preg] = 1'b1;
      free_cnt--;
      arch_val[inst_rd[k]]    = exec_op(inst_uop[k], a, b);
      // Pipe result comes from the packet alone
      inst_wdata[k] = exec_op(issue_pkt.uop, issue_pkt.op1, issue_pkt.op2);
      comp_due[k]   = cyc + 1 + int'($urandom_range(0, 4));
      comp_list.push_back(k);
      commit_list.push_back(k);
    end
  endtask

  initial begin
    int          fidx;
    int          iidx;
    int          hold;
    int          ck;
    logic        fetch_fire;
    logic        issue_fire;
    logic [1:0]  held_val;
    issue_pkt_t  held_pkt;

    void'($urandom(45));
    rst         = 1'b1;
    fetch_val   = 1'b0;
    fetch_pkt   = '0;
    issue_rdy   = 2'b00;
    complete_in = '0;
    commit_in   = '0;
    fidx = 0;
    iidx = 0;
    hold = 0;
    cyc  = 0;
    fetch_fire = 1'b0;
    held_val   = 2'b00;
    held_pkt   = '0;
    for (int k = 0; k < N_INST; k++) make_inst(k);
    model_reset();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    while (iidx < N_INST || comp_list.size() != 0 || commit_list.size() != 0) begin
      @(negedge clk);
      // ---- stand-in fetch
      if (fetch_fire) fetch_val = 1'b0;
      if (!fetch_val && fidx < N_INST && $urandom_range(0, 9) < 8) begin
        fetch_val         = 1'b1;
        fetch_pkt.inst    = inst_word[fidx];
        fetch_pkt.pc      = 32'h1000 + 32'(fidx * 4);
        fetch_pkt.seq_num = `SEQ_BITS'(fidx);
      end
      issue_rdy = {1'($urandom_range(0, 9) < 7), 1'($urandom_range(0, 9) < 7)};
      // ---- completions, one per cycle, first one due
      complete_in = '0;
      for (int i = 0; i < comp_list.size(); i++) begin
        ck = comp_list[i];
        if (comp_due[ck] <= cyc) begin
          complete_in.val     = 1'b1;
          complete_in.wen     = 1'b1;
          complete_in.preg    = inst_preg[ck];
          complete_in.wdata   = inst_wdata[ck];
          complete_in.seq_num = `SEQ_BITS'(ck);
          comp_cycle[ck]      = cyc;
          comp_list.delete(i);
          break;
        end
      end
      // ---- in-order commits, sometimes held back
      commit_in = '0;
      if (hold > 0) begin
        hold--;
      end else if ($urandom_range(0, 49) == 0) begin
        hold = $urandom_range(20, 60);
      end else if (commit_list.size() != 0) begin
        ck = commit_list[0];
        if (comp_cycle[ck] >= 0 && cyc > comp_cycle[ck]) begin
          commit_in.val   = 1'b1;
          commit_in.ppreg = inst_ppreg[ck];
          void'(commit_list.pop_front());
        end
      end
      #1;
      if (cyc == 0) begin
        assert (fetch_rdy) else fail_plain("fetch_rdy low in first cycle after reset");
      end
      assert (issue_val != 2'b11) else fail_plain("both issue_val bits high at once");
      // Stalled packet must hold still
      if (held_val != 2'b00) begin
        check_field("issue_val", 32'(issue_val), 32'(held_val));
        assert (issue_pkt === held_pkt) else fail_plain("issue_pkt changed under back-pressure");
      end
      issue_fire = |(issue_val & issue_rdy);
      if (issue_val != 2'b00 && !issue_fire) begin
        check_field("fetch_rdy", 32'(fetch_rdy), 32'h0);
        held_val = issue_val;
        held_pkt = issue_pkt;
      end else begin
        held_val = 2'b00;
      end
      if (issue_fire) begin
        assert (iidx < fidx) else fail_plain("issue without a fetched instruction");
        take_issue(iidx);
        iidx++;
      end
      // Commit counts after the issue check, same edge
      if (commit_in.val) model_commit(commit_in.ppreg);
      fetch_fire = fetch_val & fetch_rdy;
      if (fetch_fire) fidx++;
      cyc++;
      if (cyc >= TIMEOUT) fail_plain("timeout waiting for instructions to drain");
    end

    // Last commit lands on the next edge
    @(negedge clk);
    check_field("free_cnt", 32'(uut.rename.free_cnt), 32'(`NUM_PREGS - 32));
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: decode_issue/decode_issue_unit.sv
// ------------------------------------------------
// Decode and issue stage top level
// Holds one fetched instruction, renames it and
// issues it to the ALU pipe or the mul pipe
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module decode_issue_unit
  import issue_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  input  logic        fetch_val,
  output logic        fetch_rdy,
  input  fetch_pkt_t  fetch_pkt,

  output logic [1:0]  issue_val,
  input  logic [1:0]  issue_rdy,
  output issue_pkt_t  issue_pkt,

  input  complete_t   complete_in,
  input  commit_t     commit_in
);

  // ------------------------------------------------
  // Fetch register
  // ------------------------------------------------

  logic       fq_val;
  fetch_pkt_t fq_pkt;
  logic       fetch_xfer;
  logic       issue_xfer;

  assign fetch_rdy  = !fq_val | issue_xfer;
  assign fetch_xfer = fetch_val & fetch_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      fq_val <= 1'b0;
    end else if (fetch_xfer) begin
      fq_val <= 1'b1;
    end else if (issue_xfer) begin
      fq_val <= 1'b0;
    end
  end

  // Payload only loads on a fetch transfer
  always_ff @(posedge clk) begin
    if (fetch_xfer) fq_pkt <= fetch_pkt;
  end

  // ------------------------------------------------
  // Decode, rename, operand read
  // ------------------------------------------------

  logic                  dec_val;
  uop_e                  dec_uop;
  logic [4:0]            dec_raddr0;
  logic [4:0]            dec_raddr1;
  logic [4:0]            dec_waddr;
  logic                  dec_wen;
  logic                  dec_op2_sel;
  logic [`XLEN-1:0]      dec_imm;

  logic [`PREG_BITS-1:0] alloc_preg;
  logic [`PREG_BITS-1:0] alloc_ppreg;
  logic                  alloc_rdy;
  logic                  need_alloc;
  logic [`PREG_BITS-1:0] src_preg0;
  logic [`PREG_BITS-1:0] src_preg1;
  logic                  src_pending0;
  logic                  src_pending1;
  logic [`XLEN-1:0]      rdata0;
  logic [`XLEN-1:0]      rdata1;

  inst_decoder decoder (
    .inst    (fq_pkt.inst),
    .dec_val (dec_val),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .op2_sel (dec_op2_sel),
    .imm     (dec_imm)
  );

  // Writes to x0 take no register
  assign need_alloc = dec_wen & (dec_waddr != 5'd0);

  rename_table rename (
    .clk             (clk),
    .rst             (rst),
    .alloc_areg      (dec_waddr),
    .alloc_en        (issue_xfer & need_alloc),
    .alloc_preg      (alloc_preg),
    .alloc_ppreg     (alloc_ppreg),
    .alloc_rdy       (alloc_rdy),
    .lookup_areg0    (dec_raddr0),
    .lookup_areg1    (dec_raddr1),
    .lookup_preg0    (src_preg0),
    .lookup_preg1    (src_preg1),
    .lookup_pending0 (src_pending0),
    .lookup_pending1 (src_pending1),
    .complete_in     (complete_in),
    .commit_in       (commit_in)
  );

  phys_regfile regfile (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (src_preg0),
    .raddr1 (src_preg1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (complete_in.val & complete_in.wen),
    .waddr  (complete_in.preg),
    .wdata  (complete_in.wdata)
  );

  // ------------------------------------------------
  // Stall and routing
  // ------------------------------------------------

  logic stall;
  logic to_mul;

  assign stall  = !dec_val | src_pending0 | src_pending1 | (need_alloc & !alloc_rdy);
  // mul goes to pipe 1, rest to pipe 0
  assign to_mul = (dec_uop == UOP_MUL);

  assign issue_val  = (fq_val & !stall) ? {to_mul, !to_mul} : 2'b00;
  // Only the routed pipe's ready counts
  assign issue_xfer = |(issue_val & issue_rdy);

  // Shared packet to both pipes
  always_comb begin
    issue_pkt.pc      = fq_pkt.pc;
    issue_pkt.op1     = rdata0;
    issue_pkt.op2     = dec_op2_sel ? dec_imm : rdata1;
    issue_pkt.uop     = dec_uop;
    issue_pkt.waddr   = dec_waddr;
    issue_pkt.seq_num = fq_pkt.seq_num;
    // Zero when nothing is allocated, so the packet holds still
    // while a commit refills an empty free list
    issue_pkt.preg    = need_alloc ? alloc_preg : '0;
    issue_pkt.ppreg   = need_alloc ? alloc_ppreg : '0;
  end

endmodule

`default_nettype wire

// File: decode_issue/phys_regfile.sv
// ------------------------------------------------
// Physical register file, 2 reads and 1 write
// Reads are combinational, written by completions
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module phys_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`PREG_BITS-1:0]  raddr0,
  input  logic [`PREG_BITS-1:0]  raddr1,
  output logic [`XLEN-1:0]       rdata0,
  output logic [`XLEN-1:0]       rdata1,
  input  logic                   wen,
  input  logic [`PREG_BITS-1:0]  waddr,
  input  logic [`XLEN-1:0]       wdata
);

  logic [`XLEN-1:0] regs [`NUM_PREGS];

  // Entry 0 is cleared on reset and never written, so it reads zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_PREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

endmodule

`default_nettype wire

// File: decode_issue/rename_table.sv
// ------------------------------------------------
// Register map table, free list and pending bits
// Lookups are combinational, updates on clk
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_table
  import issue_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  input  logic [4:0]             alloc_areg,
  input  logic                   alloc_en,
  output logic [`PREG_BITS-1:0]  alloc_preg,
  output logic [`PREG_BITS-1:0]  alloc_ppreg,
  output logic                   alloc_rdy,

  input  logic [4:0]             lookup_areg0,
  input  logic [4:0]             lookup_areg1,
  output logic [`PREG_BITS-1:0]  lookup_preg0,
  output logic [`PREG_BITS-1:0]  lookup_preg1,
  output logic                   lookup_pending0,
  output logic                   lookup_pending1,

  input  complete_t              complete_in,
  input  commit_t                commit_in
);

  localparam int PREG_W     = `PREG_BITS;
  localparam int FREE_DEPTH = `NUM_PREGS - `NUM_AREGS;
  localparam int PTR_BITS   = (FREE_DEPTH > 1) ? $clog2(FREE_DEPTH) : 1;
  localparam int CNT_BITS   = $clog2(FREE_DEPTH + 1);

  logic [`PREG_BITS-1:0] map_table [`NUM_AREGS];
  logic [`NUM_PREGS-1:0] pending;

  // Free list storage, circular
  logic [`PREG_BITS-1:0] free_mem [FREE_DEPTH];
  logic [PTR_BITS-1:0]   head;
  logic [PTR_BITS-1:0]   tail;
  logic [CNT_BITS-1:0]   free_cnt;

  logic alloc_go;
  logic free_go;

  // Wrap at depth, which need not be a power of two
  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
    ptr_inc = (p == PTR_BITS'(FREE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign alloc_rdy   = (free_cnt != '0);
  // x0 is never renamed
  assign alloc_go    = alloc_en & alloc_rdy & (alloc_areg != 5'd0);
  assign free_go     = commit_in.val;

  assign alloc_preg  = free_mem[head];
  assign alloc_ppreg = map_table[alloc_areg];

  // Source lookups
  assign lookup_preg0    = map_table[lookup_areg0];
  assign lookup_preg1    = map_table[lookup_areg1];
  assign lookup_pending0 = pending[lookup_preg0];
  assign lookup_pending1 = pending[lookup_preg1];

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map, spare registers on the free list
      for (int i = 0; i < `NUM_AREGS; i++) begin
        map_table[i] <= PREG_W'(i);
      end
      for (int j = 0; j < FREE_DEPTH; j++) begin
        free_mem[j] <= PREG_W'(`NUM_AREGS + j);
      end
      pending  <= '0;
      head     <= '0;
      tail     <= '0;
      free_cnt <= CNT_BITS'(FREE_DEPTH);
    end else begin
      if (alloc_go) begin
        map_table[alloc_areg] <= alloc_preg;
        head                  <= ptr_inc(head);
      end
      // Commit returns the old mapping
      if (free_go) begin
        free_mem[tail] <= commit_in.ppreg;
        tail           <= ptr_inc(tail);
      end
      free_cnt <= free_cnt + CNT_BITS'(free_go) - CNT_BITS'(alloc_go);

      // New preg is free, so never the one completing
      if (complete_in.val) pending[complete_in.preg] <= 1'b0;
      if (alloc_go) pending[alloc_preg] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
// ------------------------------------------------
// Combinational decoder for the ALU and mul subset
// Also produces the sign-extended I-type immediate
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module inst_decoder
  import issue_pkg::*;
(
  input  inst_word_u        inst,
  output logic              dec_val,
  output uop_e              uop,
  output logic [4:0]        raddr0,
  output logic [4:0]        raddr1,
  output logic [4:0]        waddr,
  output logic              wen,
  output logic              op2_sel,
  output logic [`XLEN-1:0]  imm
);

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 values for the R-type group
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;
  localparam logic [6:0] F7_MUL  = 7'b0000001;

  always_comb begin
    // Defaults describe an invalid word
    dec_val = 1'b0;
    uop     = UOP_INVALID;
    raddr0  = 5'd0;
    raddr1  = 5'd0;
    waddr   = 5'd0;
    wen     = 1'b0;
    op2_sel = 1'b0;
    imm     = '0;

    case (inst.r.opcode)
      OPC_OP: begin
        // R-type view
        if (inst.r.funct7 == F7_BASE && inst.r.funct3 == 3'b000) uop = UOP_ADD;
        if (inst.r.funct7 == F7_ALT  && inst.r.funct3 == 3'b000) uop = UOP_SUB;
        if (inst.r.funct7 == F7_BASE && inst.r.funct3 == 3'b111) uop = UOP_AND;
        if (inst.r.funct7 == F7_BASE && inst.r.funct3 == 3'b110) uop = UOP_OR;
        if (inst.r.funct7 == F7_MUL  && inst.r.funct3 == 3'b000) uop = UOP_MUL;
        if (uop != UOP_INVALID) begin
          dec_val = 1'b1;
          raddr0  = inst.r.rs1;
          raddr1  = inst.r.rs2;
          waddr   = inst.r.rd;
          wen     = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        // I-type view, only addi; rs2 slot left at x0 so it never stalls
        if (inst.i.funct3 == 3'b000) begin
          dec_val = 1'b1;
          uop     = UOP_ADDI;
          raddr0  = inst.i.rs1;
          waddr   = inst.i.rd;
          wen     = 1'b1;
          op2_sel = 1'b1;
          imm     = {{(`XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
        end
      end
      default: begin
        // Unknown opcode, defaults stand
        dec_val = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: common/issue_pkg.sv
// ------------------------------------------------
// Shared types for the decode and issue stage
// Import with a wildcard in the module header
// ------------------------------------------------

`default_nettype none

`include "rename_config.svh"

package issue_pkg;

  // Micro-ops handled by the two pipes
  typedef enum logic [2:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_OR,
    UOP_ADDI,
    UOP_MUL,
    UOP_INVALID
  } uop_e;

  // R-type view of an instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // I-type view of the same word
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } inst_word_u;

  // ------------------------------------------------
  // Packets between stages
  // ------------------------------------------------

  // From fetch, 72 bits
  typedef struct packed {
    inst_word_u             inst;
    logic [`XLEN-1:0]       pc;
    logic [`SEQ_BITS-1:0]   seq_num;
  } fetch_pkt_t;

  // To either pipe
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    uop_e                   uop;
    logic [4:0]             waddr;
    logic [`SEQ_BITS-1:0]   seq_num;
    logic [`PREG_BITS-1:0]  preg;
    logic [`PREG_BITS-1:0]  ppreg;
  } issue_pkt_t;

  // Completion strobe from a pipe
  typedef struct packed {
    logic                   val;
    logic                   wen;
    logic [`PREG_BITS-1:0]  preg;
    logic [`XLEN-1:0]       wdata;
    logic [`SEQ_BITS-1:0]   seq_num;
  } complete_t;

  // Commit strobe, in program order
  typedef struct packed {
    logic                   val;
    logic [`PREG_BITS-1:0]  ppreg;
  } commit_t;

endpackage

`default_nettype wire

// File: common/rename_config.svh
// ------------------------------------------------
// Sizes for the decode and issue stage
// Include wherever register counts or widths are needed
// ------------------------------------------------

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Architectural register count, fixed by the ISA
`define NUM_AREGS 32

// Physical register count, anything above NUM_AREGS works
`define NUM_PREGS 40

// Physical register index width
`define PREG_BITS 6

// Sequence number and data widths
`define SEQ_BITS 8
`define XLEN 32

`endif
